// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = scalar_core_tb
FILELIST  = scalar_core.f
BUILD_DIR = obj_dir
PASS_MSG  = ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== scalar_core.f ====
src/scalar_core_pkg.sv
src/instr_mem.sv
src/fetch_stage.sv
src/issue_stage.sv
src/reg_read_stage.sv
src/exec_stage.sv
src/scalar_core.sv
testbench/scalar_core_tb.sv

// ==== src/exec_stage.sv ====
// Negative flag is the sign bit of src1 - src2, so signed overflow is not corrected
`timescale 1ns/1ps

module exec_stage
	import scalar_core_pkg::*;
(
	input  logic      clock,
	input  logic      reset,
	input  exec_cmd_t exec_cmd,
	output wb_t       wb,
	output status_t   status,
	output logic      status_written,
	output data_t     scalar_data,
	output logic      scalar_valid,
	output logic      term
);

	data_t imm_ext;
	data_t diff;
	data_t result;
	logic is_cmp;
	logic is_out;

	assign imm_ext = {{16{exec_cmd.imm[15]}}, exec_cmd.imm};
	assign diff    = exec_cmd.operand1 - exec_cmd.operand2;
	assign is_cmp  = exec_cmd.valid && exec_cmd.opcode == OP_CMP;
	assign is_out  = exec_cmd.valid && exec_cmd.opcode == OP_OUT;

	//////////////////////////////////////////////////
	// Integer ALU
	//////////////////////////////////////////////////
	always_comb begin
		case (exec_cmd.opcode)
			OP_ADDI: result = exec_cmd.operand1 + imm_ext;
			OP_ADD:  result = exec_cmd.operand1 + exec_cmd.operand2;
			OP_SUB:  result = diff;
			OP_AND:  result = exec_cmd.operand1 & exec_cmd.operand2;
			OP_OR:   result = exec_cmd.operand1 | exec_cmd.operand2;
			OP_XOR:  result = exec_cmd.operand1 ^ exec_cmd.operand2;
			OP_SHL:  result = exec_cmd.operand1 << exec_cmd.operand2[4:0];
			default: result = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wb             <= '0;
			status         <= '0;
			status_written <= 1'b0;
			scalar_valid   <= 1'b0;
			term           <= 1'b0;
		end else begin
			wb.valid       <= exec_cmd.valid & writes_reg(exec_cmd.opcode);
			wb.dst         <= exec_cmd.dst;
			wb.data        <= result;
			status_written <= is_cmp;
			scalar_valid   <= is_out;
			term           <= exec_cmd.valid && exec_cmd.opcode == OP_HALT;
			// Flags change only on compare
			if (is_cmp) begin
				status.zero     <= (diff == '0);
				status.negative <= diff[31];
			end
		end
	end

	// Output value holds until the next OUT
	always_ff @(posedge clock) begin
		if (is_out)
			scalar_data <= exec_cmd.operand1;
	end

endmodule

// ==== src/fetch_stage.sv ====
// Branch targets use only the low address bits of the immediate; start restarts at address 0
`timescale 1ns/1ps

module fetch_stage
	import scalar_core_pkg::*;
#(
	parameter int IMEM_ADDR_WIDTH = 6
) (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       start,
	input  logic                       stall,
	input  logic                       redirect,
	input  imm_t                       target,
	input  logic                       halt,
	input  instr_t                     rd_instr,
	output logic                       running,
	output logic                       rd_en,
	output logic [IMEM_ADDR_WIDTH-1:0] rd_addr,
	output logic                       fetch_valid,
	output instr_t                     fetch_instr
);

	// Address of the next read
	logic [IMEM_ADDR_WIDTH-1:0] pc;

	assign rd_en       = running & ~stall;
	assign rd_addr     = pc;
	assign fetch_instr = rd_instr;

	always_ff @(posedge clock) begin
		if (reset) begin
			running     <= 1'b0;
			pc          <= '0;
			fetch_valid <= 1'b0;
		end else if (start) begin
			running     <= 1'b1;
			pc          <= '0;
			fetch_valid <= 1'b0;
		end else if (halt) begin
			running     <= 1'b0;
			fetch_valid <= 1'b0;
		end else if (redirect) begin
			// Drop the read already in flight
			pc          <= target[IMEM_ADDR_WIDTH-1:0];
			fetch_valid <= 1'b0;
		end else if (!stall) begin
			fetch_valid <= running;
			if (running)
				pc <= pc + 1'b1;
		end
	end

endmodule

// ==== src/instr_mem.sv ====
// Stores append from address 0 after reset only and wrap silently at the array size
`timescale 1ns/1ps

module instr_mem
	import scalar_core_pkg::*;
#(
	parameter int IMEM_ADDR_WIDTH = 6
) (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       req_st,
	input  instr_t                     st_instr,
	input  logic                       running,
	input  logic                       rd_en,
	input  logic [IMEM_ADDR_WIDTH-1:0] rd_addr,
	output logic                       ack_st,
	output instr_t                     rd_instr
);

	instr_t mem [2**IMEM_ADDR_WIDTH];
	logic [IMEM_ADDR_WIDTH-1:0] st_ptr;
	logic st_en;

	// Stores are only taken while the core is idle
	assign st_en = req_st & ~running;

	always_ff @(posedge clock) begin
		if (reset) begin
			st_ptr <= '0;
			ack_st <= 1'b0;
		end else begin
			ack_st <= st_en;
			if (st_en)
				st_ptr <= st_ptr + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (st_en)
			mem[st_ptr] <= st_instr;
		// Read data holds while fetch is stalled
		if (rd_en)
			rd_instr <= mem[rd_addr];
	end

endmodule

// ==== src/issue_stage.sv ====
// In-order issue without forwarding; BRZ and CMP wait until no CMP is outstanding
`timescale 1ns/1ps

module issue_stage
	import scalar_core_pkg::*;
(
	input  logic       clock,
	input  logic       reset,
	input  logic       fetch_valid,
	input  instr_t     fetch_instr,
	input  wb_t        wb,
	input  logic       status_written,
	input  status_t    status,
	output logic       stall,
	output logic       redirect,
	output imm_t       target,
	output logic       halt,
	output issue_cmd_t cmd
);

	logic [15:0] busy;
	logic [15:0] busy_now;
	logic status_busy;
	opcode_t op;
	logic hazard;
	logic go;
	logic is_branch;

	assign op = fetch_instr.opcode;

	// A write-back this cycle releases its register in time for the read stage
	assign busy_now = busy & ~((16'(wb.valid)) << wb.dst);

	assign hazard = (reads_src1(op) & busy_now[fetch_instr.src1])
		| (reads_src2(op) & busy_now[fetch_instr.src2])
		| (writes_reg(op) & busy_now[fetch_instr.dst])
		| ((op == OP_CMP || op == OP_BRZ) & status_busy);

	assign stall     = fetch_valid & hazard;
	assign go        = fetch_valid & ~hazard;
	assign is_branch = (op == OP_JMP) || (op == OP_BRZ);

	//////////////////////////////////////////////////
	// Branch resolution and halt
	//////////////////////////////////////////////////
	assign redirect = go & ((op == OP_JMP) | ((op == OP_BRZ) & status.zero));
	assign target   = fetch_instr.imm;
	assign halt     = go & (op == OP_HALT);

	// Set wins over clear on the same register
	always_ff @(posedge clock) begin
		if (reset) begin
			busy        <= '0;
			status_busy <= 1'b0;
		end else begin
			if (wb.valid)
				busy[wb.dst] <= 1'b0;
			if (go && writes_reg(op))
				busy[fetch_instr.dst] <= 1'b1;
			if (status_written)
				status_busy <= 1'b0;
			if (go && op == OP_CMP)
				status_busy <= 1'b1;
		end
	end

	// Branches leave as NOP tokens
	always_ff @(posedge clock) begin
		if (reset) begin
			cmd <= '0;
		end else begin
			cmd.valid  <= go;
			cmd.opcode <= is_branch ? OP_NOP : op;
			cmd.dst    <= fetch_instr.dst;
			cmd.src1   <= fetch_instr.src1;
			cmd.src2   <= fetch_instr.src2;
			cmd.imm    <= fetch_instr.imm;
		end
	end

endmodule

// ==== src/reg_read_stage.sv ====
// Sixteen registers in two banks of eight, all cleared by reset; reads see a same-cycle write
`timescale 1ns/1ps

module reg_read_stage
	import scalar_core_pkg::*;
(
	input  logic       clock,
	input  logic       reset,
	input  issue_cmd_t cmd,
	input  wb_t        wb,
	output exec_cmd_t  exec_cmd
);

	data_t bank_even [8];
	data_t bank_odd  [8];
	data_t operand1;
	data_t operand2;

	// Write-first read of one register
	function automatic data_t read_reg(reg_idx_t idx);
		data_t value;
		if (wb.valid && wb.dst == idx)
			value = wb.data;
		else if (idx[0])
			value = bank_odd[idx[3:1]];
		else
			value = bank_even[idx[3:1]];
		return value;
	endfunction

	//////////////////////////////////////////////////
	// Write-back into the bank picked by bit 0
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 8; i++) begin
				bank_even[i] <= '0;
				bank_odd[i]  <= '0;
			end
		end else if (wb.valid) begin
			if (wb.dst[0])
				bank_odd[wb.dst[3:1]] <= wb.data;
			else
				bank_even[wb.dst[3:1]] <= wb.data;
		end
	end

	always_comb begin
		operand1 = read_reg(cmd.src1);
		operand2 = read_reg(cmd.src2);
	end

	// Operand register toward execute
	always_ff @(posedge clock) begin
		if (reset) begin
			exec_cmd <= '0;
		end else begin
			exec_cmd.valid    <= cmd.valid;
			exec_cmd.opcode   <= cmd.opcode;
			exec_cmd.dst      <= cmd.dst;
			exec_cmd.operand1 <= operand1;
			exec_cmd.operand2 <= operand2;
			exec_cmd.imm      <= cmd.imm;
		end
	end

endmodule

// ==== src/scalar_core.sv ====
// No back-pressure on the outputs; stores are ignored while a program runs
`timescale 1ns/1ps

module scalar_core
	import scalar_core_pkg::*;
#(
	parameter int IMEM_ADDR_WIDTH = 6
) (
	input  logic    clock,
	input  logic    reset,
	input  logic    req_st,
	input  instr_t  st_instr,
	output logic    ack_st,
	input  logic    start,
	output logic    term,
	output data_t   scalar_data,
	output logic    scalar_valid,
	output status_t status
);

	logic running;
	logic rd_en;
	logic [IMEM_ADDR_WIDTH-1:0] rd_addr;
	instr_t rd_instr;
	logic fetch_valid;
	instr_t fetch_instr;
	logic stall;
	logic redirect;
	imm_t target;
	logic halt;
	issue_cmd_t issue_cmd;
	exec_cmd_t exec_cmd;
	wb_t wb;
	logic status_written;

	instr_mem #(.IMEM_ADDR_WIDTH(IMEM_ADDR_WIDTH)) instr_mem_i (
		.clock(clock), .reset(reset), .req_st(req_st), .st_instr(st_instr),
		.running(running), .rd_en(rd_en), .rd_addr(rd_addr),
		.ack_st(ack_st), .rd_instr(rd_instr)
	);

	fetch_stage #(.IMEM_ADDR_WIDTH(IMEM_ADDR_WIDTH)) fetch_stage_i (
		.clock(clock), .reset(reset), .start(start), .stall(stall),
		.redirect(redirect), .target(target), .halt(halt), .rd_instr(rd_instr),
		.running(running), .rd_en(rd_en), .rd_addr(rd_addr),
		.fetch_valid(fetch_valid), .fetch_instr(fetch_instr)
	);

	issue_stage issue_stage_i (
		.clock(clock), .reset(reset), .fetch_valid(fetch_valid),
		.fetch_instr(fetch_instr), .wb(wb), .status_written(status_written),
		.status(status), .stall(stall), .redirect(redirect), .target(target),
		.halt(halt), .cmd(issue_cmd)
	);

	reg_read_stage reg_read_stage_i (
		.clock(clock), .reset(reset), .cmd(issue_cmd), .wb(wb), .exec_cmd(exec_cmd)
	);

	exec_stage exec_stage_i (
		.clock(clock), .reset(reset), .exec_cmd(exec_cmd), .wb(wb), .status(status),
		.status_written(status_written), .scalar_data(scalar_data),
		.scalar_valid(scalar_valid), .term(term)
	);

endmodule

// ==== src/scalar_core_pkg.sv ====
// Shared types of the scalar core; instr_t is 32 bits wide and opcodes 13 to 15 behave as NOP
package scalar_core_pkg;

	typedef logic [31:0] data_t;
	typedef logic [3:0]  reg_idx_t;
	typedef logic [15:0] imm_t;

	typedef enum logic [3:0] {
		OP_NOP  = 4'd0,
		OP_ADDI = 4'd1,
		OP_ADD  = 4'd2,
		OP_SUB  = 4'd3,
		OP_AND  = 4'd4,
		OP_OR   = 4'd5,
		OP_XOR  = 4'd6,
		OP_SHL  = 4'd7,
		OP_CMP  = 4'd8,
		OP_JMP  = 4'd9,
		OP_BRZ  = 4'd10,
		OP_OUT  = 4'd11,
		OP_HALT = 4'd12
	} opcode_t;

	typedef struct packed {
		logic zero;
		logic negative;
	} status_t;

	// Instruction word as stored in the instruction memory
	typedef struct packed {
		opcode_t  opcode;
		reg_idx_t dst;
		reg_idx_t src1;
		reg_idx_t src2;
		imm_t     imm;
	} instr_t;

	// Issue to register read
	typedef struct packed {
		logic     valid;
		opcode_t  opcode;
		reg_idx_t dst;
		reg_idx_t src1;
		reg_idx_t src2;
		imm_t     imm;
	} issue_cmd_t;

	// Register read to execute
	typedef struct packed {
		logic     valid;
		opcode_t  opcode;
		reg_idx_t dst;
		data_t    operand1;
		data_t    operand2;
		imm_t     imm;
	} exec_cmd_t;

	typedef struct packed {
		logic     valid;
		reg_idx_t dst;
		data_t    data;
	} wb_t;

	function automatic logic writes_reg(opcode_t op);
		return op inside {OP_ADDI, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL};
	endfunction

	function automatic logic reads_src1(opcode_t op);
		return op inside {OP_ADDI, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL,
			OP_CMP, OP_OUT};
	endfunction

	function automatic logic reads_src2(opcode_t op);
		return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_CMP};
	endfunction

endpackage

// ==== testbench/scalar_core_tb.sv ====
// Programs must end in HALT and fit in 64 words; each test resets the core before loading
`timescale 1ns/1ps

module scalar_core_tb
	import scalar_core_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int NUM_TESTS  = 5;
	localparam int SEED       = 32'h7fbacb17;

	logic    clock;
	logic    reset;
	logic    req_st;
	instr_t  st_instr;
	logic    ack_st;
	logic    start;
	logic    term;
	data_t   scalar_data;
	logic    scalar_valid;
	status_t status;

	instr_t  prog [$];
	data_t   out_q [$];
	data_t   exp_q [$];
	data_t   first_q [$];
	data_t   m_regs [16];
	status_t m_status;
	int      ack_count;
	int      term_count;

	scalar_core #(.IMEM_ADDR_WIDTH(6)) scalar_core_i (
		.clock(clock), .reset(reset), .req_st(req_st), .st_instr(st_instr),
		.ack_st(ack_st), .start(start), .term(term), .scalar_data(scalar_data),
		.scalar_valid(scalar_valid), .status(status)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	// Outputs are stable at the falling edge
	always @(negedge clock) begin
		if (!reset) begin
			if (scalar_valid)
				out_q.push_back(scalar_data);
			if (ack_st)
				ack_count++;
			if (term)
				term_count++;
		end
	end

	initial begin
		#(NUM_TESTS * 2000 * CLK_PERIOD);
		$display("CHECKS FAILED");
		$fatal(1, "Timeout, the tests did not finish within %0d cycles", NUM_TESTS * 2000);
	end

	task automatic compare_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: actual 0x%h, expected 0x%h", name, actual, expected);
			$display("CHECKS FAILED");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	task automatic append_instr(input opcode_t op, input int dst, input int src1,
		input int src2, input int imm);
		instr_t ins;
		ins = '{op, reg_idx_t'(dst), reg_idx_t'(src1), reg_idx_t'(src2), imm_t'(imm)};
		prog.push_back(ins);
	endtask

	task automatic apply_reset();
		@(negedge clock);
		reset = 1'b1;
		repeat (3) @(negedge clock);
		prog.delete();
		out_q.delete();
		ack_count  = 0;
		term_count = 0;
		foreach (m_regs[i])
			m_regs[i] = '0;
		m_status = '0;
		reset = 1'b0;
	endtask

	// Back-to-back stores, one ack per store
	task automatic store_program();
		foreach (prog[i]) begin
			st_instr = prog[i];
			req_st   = 1'b1;
			@(negedge clock);
			compare_value("ack_st", {31'b0, ack_st}, 32'd1);
		end
		req_st   = 1'b0;
		st_instr = '0;
		@(negedge clock);
		compare_value("ack_st", {31'b0, ack_st}, 32'd0);
		compare_value("ack count", ack_count, prog.size());
	endtask

	//////////////////////////////////////////////////
	// Instruction set model, one instruction per step
	//////////////////////////////////////////////////
	task automatic run_model();
		int     pc;
		bit     done;
		instr_t ins;
		data_t  a;
		data_t  b;
		data_t  diff;
		pc   = 0;
		done = 1'b0;
		exp_q.delete();
		while (!done && pc < prog.size()) begin
			ins = prog[pc];
			a   = m_regs[ins.src1];
			b   = m_regs[ins.src2];
			pc++;
			case (ins.opcode)
				OP_ADDI: m_regs[ins.dst] = a + {{16{ins.imm[15]}}, ins.imm};
				OP_ADD:  m_regs[ins.dst] = a + b;
				OP_SUB:  m_regs[ins.dst] = a - b;
				OP_AND:  m_regs[ins.dst] = a & b;
				OP_OR:   m_regs[ins.dst] = a | b;
				OP_XOR:  m_regs[ins.dst] = a ^ b;
				OP_SHL:  m_regs[ins.dst] = a << b[4:0];
				OP_CMP: begin
					diff = a - b;
					m_status.zero     = (a == b);
					m_status.negative = diff[31];
				end
				OP_JMP:  pc = int'(ins.imm);
				OP_BRZ:  pc = m_status.zero ? int'(ins.imm) : pc;
				OP_OUT:  exp_q.push_back(a);
				OP_HALT: done = 1'b1;
				default: ;
			endcase
		end
	endtask

	// Start, optionally try a store while running, wait for term and compare
	task automatic run_program_checked(input bit stray_store);
		int ack_before;
		run_model();
		out_q.delete();
		term_count = 0;
		ack_before = ack_count;
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
		if (stray_store) begin
			req_st   = 1'b1;
			st_instr = '{OP_HALT, 4'd0, 4'd0, 4'd0, 16'd0};
			@(negedge clock);
			req_st = 1'b0;
			compare_value("ack_st", {31'b0, ack_st}, 32'd0);
			@(negedge clock);
			compare_value("ack_st", {31'b0, ack_st}, 32'd0);
		end
		do
			@(negedge clock);
		while (!term);
		repeat (6) @(negedge clock);
		compare_value("scalar_valid count", out_q.size(), exp_q.size());
		foreach (exp_q[i])
			compare_value($sformatf("scalar_data[%0d]", i), out_q[i], exp_q[i]);
		compare_value("term count", term_count, 32'd1);
		compare_value("status", {30'b0, status}, {30'b0, m_status});
		compare_value("ack count", ack_count, ack_before);
	endtask

	task automatic load_check();
		apply_reset();
		append_instr(OP_ADDI, 1, 0, 0, 3);
		append_instr(OP_ADDI, 2, 1, 0, 4);
		append_instr(OP_ADD, 3, 1, 2, 0);
		append_instr(OP_OUT, 0, 3, 0, 0);
		append_instr(OP_OUT, 0, 2, 0, 0);
		append_instr(OP_HALT, 0, 0, 0, 0);
		store_program();
		run_program_checked(1'b1);
	endtask

	// Every step reads the result of the one before
	task automatic arithmetic_chain();
		opcode_t ops[6] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL};
		apply_reset();
		append_instr(OP_ADDI, 1, 0, 0, 'h1234);
		append_instr(OP_ADDI, 2, 0, 0, 'hfff3);
		append_instr(OP_OUT, 0, 2, 0, 0);
		foreach (ops[i]) begin
			append_instr(ops[i], 1 + (i % 2), 1, 2, 0);
			append_instr(OP_OUT, 0, 1 + (i % 2), 0, 0);
		end
		append_instr(OP_HALT, 0, 0, 0, 0);
		store_program();
		run_program_checked(1'b0);
	endtask

	task automatic branch_paths();
		apply_reset();
		append_instr(OP_ADDI, 1, 0, 0, 7);
		append_instr(OP_ADDI, 2, 0, 0, 7);
		append_instr(OP_ADDI, 3, 0, 0, 9);
		append_instr(OP_CMP, 0, 1, 2, 0);
		append_instr(OP_BRZ, 0, 0, 0, 6);
		append_instr(OP_OUT, 0, 3, 0, 0);
		append_instr(OP_OUT, 0, 1, 0, 0);
		append_instr(OP_CMP, 0, 1, 3, 0);
		append_instr(OP_BRZ, 0, 0, 0, 11);
		append_instr(OP_OUT, 0, 2, 0, 0);
		append_instr(OP_JMP, 0, 0, 0, 12);
		append_instr(OP_OUT, 0, 3, 0, 0);
		append_instr(OP_HALT, 0, 0, 0, 0);
		store_program();
		run_program_checked(1'b0);
	endtask

	// The OUT behind HALT must never show up
	task automatic halt_restart();
		apply_reset();
		append_instr(OP_ADDI, 1, 0, 0, 5);
		append_instr(OP_ADDI, 2, 1, 0, 6);
		append_instr(OP_OUT, 0, 2, 0, 0);
		append_instr(OP_HALT, 0, 0, 0, 0);
		append_instr(OP_OUT, 0, 1, 0, 0);
		store_program();
		run_program_checked(1'b0);
		first_q = out_q;
		run_program_checked(1'b0);
		compare_value("rerun output count", out_q.size(), first_q.size());
		foreach (first_q[i])
			compare_value($sformatf("rerun scalar_data[%0d]", i), out_q[i], first_q[i]);
	endtask

	task automatic random_program();
		opcode_t ops[9] = '{OP_ADDI, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL,
			OP_CMP, OP_OUT};
		apply_reset();
		repeat (30) begin
			append_instr(ops[$urandom_range(8)], $urandom_range(15), $urandom_range(15),
				$urandom_range(15), $urandom_range(16'hffff));
		end
		append_instr(OP_HALT, 0, 0, 0, 0);
		store_program();
		run_program_checked(1'b0);
	endtask

	initial begin
		void'($urandom(SEED));
		reset      = 1'b1;
		req_st     = 1'b0;
		st_instr   = '0;
		start      = 1'b0;
		ack_count  = 0;
		term_count = 0;
		load_check();
		arithmetic_chain();
		branch_paths();
		halt_restart();
		random_program();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule
